// File: hw/mips_mem_pkg.sv
package mips_mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [3:0]  byte_en_t;   // Bit 0 is the lowest byte lane
    typedef logic [1:0]  byte_idx_t;

    typedef enum logic [1:0] {
        TYPE_R         = 2'd0,
        TYPE_MEM_LOAD  = 2'd1,
        TYPE_MEM_STORE = 2'd2,
        TYPE_J         = 2'd3
    } instr_type_t;

    localparam opcode_t OP_LB  = 6'b100000;
    localparam opcode_t OP_LH  = 6'b100001;
    localparam opcode_t OP_LWL = 6'b100010;
    localparam opcode_t OP_LW  = 6'b100011;
    localparam opcode_t OP_LBU = 6'b100100;
    localparam opcode_t OP_LHU = 6'b100101;
    localparam opcode_t OP_LWR = 6'b100110;
    localparam opcode_t OP_SB  = 6'b101000;
    localparam opcode_t OP_SH  = 6'b101001;
    localparam opcode_t OP_SW  = 6'b101011;
    localparam opcode_t OP_LUI = 6'b001111;

    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;

    typedef logic [RAM_AW-1:0] ram_addr_t;

    // Load state carried across the RAM read cycle
    typedef struct packed {
        opcode_t   op;
        byte_idx_t byte_idx;
        word_t     rt_data;
    } load_ctx_t;

endpackage

// File: hw/mips_cpu_memint.sv
`timescale 1ns/1ps

module mips_cpu_memint import mips_mem_pkg::*; (
    input  word_t       cpu_out,
    input  opcode_t     op,
    input  instr_type_t instr_type,
    output word_t       mem_addr,
    output byte_en_t    byteenable
);

    byte_idx_t byte_idx;
    logic      is_mem;

    assign byte_idx = cpu_out[1:0];
    assign mem_addr = {cpu_out[31:2], 2'b00};   // Word aligned
    assign is_mem   = (instr_type == TYPE_MEM_LOAD) || (instr_type == TYPE_MEM_STORE);

    always_comb begin
        byteenable = 4'b0000;
        if (is_mem) begin
            case (op)
                OP_LB, OP_LBU, OP_SB: begin
                    byteenable = 4'b0001 << byte_idx;
                end
                OP_LH, OP_LHU, OP_SH: begin
                    case (byte_idx)
                        2'd0:    byteenable = 4'b0011;
                        2'd2:    byteenable = 4'b1100;
                        default: byteenable = 4'b0000;   // Odd offset
                    endcase
                end
                OP_LW, OP_SW, OP_LUI: begin
                    byteenable = 4'b1111;
                end
                OP_LWL: begin
                    case (byte_idx)
                        2'd0:    byteenable = 4'b1111;
                        2'd1:    byteenable = 4'b1110;
                        2'd2:    byteenable = 4'b1100;
                        default: byteenable = 4'b1000;
                    endcase
                end
                OP_LWR: begin
                    case (byte_idx)
                        2'd0:    byteenable = 4'b0001;
                        2'd1:    byteenable = 4'b0011;
                        2'd2:    byteenable = 4'b0111;
                        default: byteenable = 4'b1111;
                    endcase
                end
                default: begin
                    byteenable = 4'b0000;
                end
            endcase
        end
        else begin
            byteenable = 4'b1111;   // Non-memory types touch the whole word
        end
    end

endmodule

// File: hw/mips_store_align.sv
`timescale 1ns/1ps

module mips_store_align import mips_mem_pkg::*; (
    input  opcode_t op,
    input  word_t   rt_data,
    output word_t   wr_data
);

    // Byte enables pick the lane out of the replicated data
    always_comb begin
        case (op)
            OP_SB: begin
                wr_data = {4{rt_data[7:0]}};
            end
            OP_SH: begin
                wr_data = {2{rt_data[15:0]}};
            end
            OP_SW: begin
                wr_data = rt_data;
            end
            default: begin
                wr_data = rt_data;
            end
        endcase
    end

endmodule

// File: hw/mips_load_extract.sv
`timescale 1ns/1ps

module mips_load_extract import mips_mem_pkg::*; (
    input  load_ctx_t ctx,
    input  word_t     rdata,
    output word_t     result
);

    logic [4:0]  lane_sh;
    logic [4:0]  lwl_sh;
    word_t       lane_word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    word_t       lwl_keep;
    word_t       lwr_keep;

    assign lane_sh   = {ctx.byte_idx, 3'b000};
    assign lwl_sh    = {~ctx.byte_idx, 3'b000};   // 8 * (3 - byte_idx)
    assign lane_word = rdata >> lane_sh;
    assign sel_byte  = lane_word[7:0];
    assign sel_half  = ctx.byte_idx[1] ? rdata[31:16] : rdata[15:0];

    // Register bytes that survive the partial word loads
    assign lwl_keep = ~(32'hffff_ffff << lwl_sh);
    assign lwr_keep = ~(32'hffff_ffff >> lane_sh);

    always_comb begin
        case (ctx.op)
            OP_LB: begin
                result = {{24{sel_byte[7]}}, sel_byte};
            end
            OP_LBU: begin
                result = {24'd0, sel_byte};
            end
            OP_LH: begin
                result = {{16{sel_half[15]}}, sel_half};
            end
            OP_LHU: begin
                result = {16'd0, sel_half};
            end
            OP_LW: begin
                result = rdata;
            end
            OP_LWL: begin
                result = (rdata << lwl_sh) | (ctx.rt_data & lwl_keep);
            end
            OP_LWR: begin
                result = (rdata >> lane_sh) | (ctx.rt_data & lwr_keep);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hw/mips_data_ram.sv
`timescale 1ns/1ps

module mips_data_ram import mips_mem_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  byte_en_t  be,
    input  logic      re,
    input  ram_addr_t waddr,
    input  word_t     wdata,
    output word_t     rdata
);

    word_t mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we && be[i]) begin
                mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[waddr];   // Holds until the next read
        end
    end

    // Single port shared by reads and writes
    a_no_rw_overlap: assert property (@(posedge clk) !(we && re))
        else $error("RAM read and write in the same cycle");

endmodule

// File: hw/mips_mem_stage.sv
`timescale 1ns/1ps

module mips_mem_stage import mips_mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_read,
    input  logic        mem_write,
    input  opcode_t     op,
    input  instr_type_t instr_type,
    input  word_t       addr,
    input  word_t       rt_data,
    output logic        load_valid,
    output word_t       load_result
);

    word_t     mem_addr;
    byte_en_t  byteenable;
    word_t     wr_data;
    word_t     rd_data;
    ram_addr_t ram_addr;
    byte_idx_t byte_idx;
    load_ctx_t ctx_q;

    assign byte_idx = addr[1:0];
    assign ram_addr = mem_addr[RAM_AW+1:2];   // Wraps modulo RAM_WORDS

    mips_cpu_memint u_memint (
        .cpu_out    (addr),
        .op         (op),
        .instr_type (instr_type),
        .mem_addr   (mem_addr),
        .byteenable (byteenable)
    );

    mips_store_align u_store_align (
        .op      (op),
        .rt_data (rt_data),
        .wr_data (wr_data)
    );

    mips_data_ram u_ram (
        .clk   (clk),
        .we    (mem_write),
        .be    (byteenable),
        .re    (mem_read),
        .waddr (ram_addr),
        .wdata (wr_data),
        .rdata (rd_data)
    );

    // Context travels alongside the RAM read
    always_ff @(posedge clk) begin
        if (mem_read) begin
            ctx_q <= '{op: op, byte_idx: byte_idx, rt_data: rt_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_valid <= 1'b0;
        end
        else begin
            load_valid <= mem_read;   // Fixed one-cycle latency
        end
    end

    mips_load_extract u_load_extract (
        .ctx    (ctx_q),
        .rdata  (rd_data),
        .result (load_result)
    );

    a_valid_after_read: assert property (
        @(posedge clk) disable iff (!rst_n) load_valid |-> $past(mem_read)
    ) else $error("load_valid without a preceding mem_read");

endmodule

// File: sim/mips_mem_checker.sv
`timescale 1ns/1ps

module mips_mem_checker import mips_mem_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mem_read,
    input  logic  load_valid,
    input  word_t load_result,
    input  logic  exp_push,
    input  word_t exp_data,
    output int    errors,
    output int    checked,
    output int    pending
);

    word_t expected_q [$];
    word_t expected;
    logic  read_q     = 1'b0;   // mem_read seen in the previous cycle
    int    err_count  = 0;
    int    load_count = 0;
    int    depth      = 0;

    assign errors  = err_count;
    assign checked = load_count;
    assign pending = depth;

    // Sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (read_q && load_valid !== 1'b1) begin
                $display("** Error at %0d ns: load_valid expected 1, actual %b",
                         $time, load_valid);
                err_count++;
                expected = expected_q.pop_front();   // Drop the lost load
            end
            else if (!read_q && load_valid !== 1'b0) begin
                $display("Unexpected load_valid pulse at %0d ns with no load pending", $time);
                err_count++;
            end
            else if (read_q) begin
                expected = expected_q.pop_front();
                load_count++;
                if (load_result !== expected) begin
                    $display("** Error at %0d ns: load_result expected %h, actual %h",
                             $time, expected, load_result);
                    err_count++;
                end
            end
            read_q = mem_read;
        end
        if (exp_push) begin
            expected_q.push_back(exp_data);
        end
        depth = expected_q.size();
    end

endmodule

// File: sim/mips_mem_stage_tb.sv
`timescale 1ns/1ps

module mips_mem_stage_tb import mips_mem_pkg::*; ();

    localparam int EXT_WORDS    = 16;   // Words used for the sub-word load sweeps
    localparam int TYPE_R_WORDS = 4;
    localparam int PART_WORD    = 37;
    localparam int N_OPS        = 3*RAM_WORDS + 16 + 24*EXT_WORDS + 3*TYPE_R_WORDS;
    localparam int CYCLE_LIMIT  = 4*N_OPS + 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        mem_read;
    logic        mem_write;
    opcode_t     op;
    instr_type_t instr_type;
    word_t       addr;
    word_t       rt_data;
    logic        load_valid;
    word_t       load_result;
    logic        exp_push;
    word_t       exp_data;
    int          errors;
    int          checked;
    int          pending;
    int          cycles;
    logic [7:0]  ref_mem [RAM_WORDS*4];   // Byte model of the RAM

    always #4 clk = ~clk;

    mips_mem_stage UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .op          (op),
        .instr_type  (instr_type),
        .addr        (addr),
        .rt_data     (rt_data),
        .load_valid  (load_valid),
        .load_result (load_result)
    );

    mips_mem_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_read    (mem_read),
        .load_valid  (load_valid),
        .load_result (load_result),
        .exp_push    (exp_push),
        .exp_data    (exp_data),
        .errors      (errors),
        .checked     (checked),
        .pending     (pending)
    );

    function automatic logic lane_enabled(opcode_t o, instr_type_t it, byte_idx_t off,
                                          byte_idx_t lane);
        logic en;
        if (it != TYPE_MEM_LOAD && it != TYPE_MEM_STORE)
            en = 1'b1;
        else if (o == OP_LB || o == OP_LBU || o == OP_SB)
            en = (lane == off);
        else if (o == OP_LH || o == OP_LHU || o == OP_SH)
            en = !off[0] && (lane[1] == off[1]);   // Odd offsets enable nothing
        else if (o == OP_LW || o == OP_SW || o == OP_LUI)
            en = 1'b1;
        else if (o == OP_LWL)
            en = (lane >= off);
        else if (o == OP_LWR)
            en = (lane <= off);
        else
            en = 1'b0;
        return en;
    endfunction

    function automatic logic [7:0] store_byte(opcode_t o, word_t d, byte_idx_t lane);
        logic [7:0] b;
        case (o)
            OP_SB:   b = d[7:0];
            OP_SH:   b = lane[0] ? d[15:8] : d[7:0];
            default: b = d[8*lane +: 8];
        endcase
        return b;
    endfunction

    function automatic word_t ref_word(word_t a);
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = ref_mem[{a[9:2], 2'(i)}];
        end
        return w;
    endfunction

    // Expected load value from the byte model and the extraction rules
    function automatic word_t expected_load(opcode_t lop, word_t a, word_t rt);
        word_t       w;
        word_t       r;
        int          off;
        logic [7:0]  b;
        logic [15:0] h;
        w   = ref_word(a);
        off = int'(a[1:0]);
        b   = w[8*off +: 8];
        h   = a[1] ? w[31:16] : w[15:0];
        r   = rt;
        case (lop)
            OP_LB:  r = {{24{b[7]}}, b};
            OP_LBU: r = {24'd0, b};
            OP_LH:  r = {{16{h[15]}}, h};
            OP_LHU: r = {16'd0, h};
            OP_LW:  r = w;
            OP_LWL: begin
                for (int i = 3 - off; i < 4; i++) begin
                    r[8*i +: 8] = w[8*(i - 3 + off) +: 8];
                end
            end
            OP_LWR: begin
                for (int i = 0; i < 4 - off; i++) begin
                    r[8*i +: 8] = w[8*(i + off) +: 8];
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic word_t word_addr(int idx, byte_idx_t off);
        word_t r;
        r = $urandom();
        return {r[31:10], idx[7:0], off};   // Random upper bits exercise the wrap
    endfunction

    function automatic byte_idx_t rand_off();
        word_t r;
        r = $urandom();
        return r[1:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic do_store(opcode_t sop, instr_type_t it, word_t a, word_t d);
        mem_write  = 1'b1;
        op         = sop;
        instr_type = it;
        addr       = a;
        rt_data    = d;
        for (int i = 0; i < 4; i++) begin
            if (lane_enabled(sop, it, a[1:0], 2'(i)))
                ref_mem[{a[9:2], 2'(i)}] = store_byte(sop, d, 2'(i));
        end
        next_cycle();
        mem_write = 1'b0;
    endtask

    task automatic do_load(opcode_t lop, word_t a, word_t rt);
        mem_read   = 1'b1;
        op         = lop;
        instr_type = TYPE_MEM_LOAD;
        addr       = a;
        rt_data    = rt;
        exp_data   = expected_load(lop, a, rt);
        exp_push   = 1'b1;
        next_cycle();
        mem_read = 1'b0;
        exp_push = 1'b0;
    endtask

    initial begin
        void'($urandom(80));
        rst_n      = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        op         = OP_LW;
        instr_type = TYPE_R;
        addr       = '0;
        rt_data    = '0;
        exp_push   = 1'b0;
        exp_data   = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (4) next_cycle();   // Idle cycles before the first load

        for (int i = 0; i < RAM_WORDS; i++) begin
            do_store(OP_SW, TYPE_MEM_STORE, word_addr(i, rand_off()), $urandom());
            do_load(OP_LW, word_addr(i, rand_off()), $urandom());
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            do_load(OP_LW, word_addr(i, 2'd0), '0);
        end

        for (int k = 0; k < 4; k++) begin
            do_store(OP_SB, TYPE_MEM_STORE, word_addr(PART_WORD, 2'(k)), $urandom());
            do_load(OP_LW, word_addr(PART_WORD, 2'd0), '0);
            do_store(OP_SH, TYPE_MEM_STORE, word_addr(PART_WORD, 2'(k)), $urandom());
            do_load(OP_LW, word_addr(PART_WORD, 2'd0), '0);
        end

        for (int w = 0; w < EXT_WORDS; w++) begin
            for (int k = 0; k < 4; k++) begin
                do_load(OP_LB, word_addr(w, 2'(k)), $urandom());
                do_load(OP_LBU, word_addr(w, 2'(k)), $urandom());
                do_load(OP_LH, word_addr(w, 2'(k)), $urandom());
                do_load(OP_LHU, word_addr(w, 2'(k)), $urandom());
                do_load(OP_LWL, word_addr(w, 2'(k)), $urandom());
                do_load(OP_LWR, word_addr(w, 2'(k)), $urandom());
            end
        end

        for (int w = 0; w < TYPE_R_WORDS; w++) begin
            do_store(OP_SW, TYPE_MEM_STORE, word_addr(100 + w, 2'd0), $urandom());
            do_store(OP_SB, TYPE_R, word_addr(100 + w, rand_off()), $urandom());
            do_load(OP_LW, word_addr(100 + w, 2'd0), '0);
        end

        wait (pending == 0);
        repeat (3) next_cycle();
        $display("Loads checked: %0d, errors: %0d", checked, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: mips_mem_stage.f
hw/mips_mem_pkg.sv
hw/mips_cpu_memint.sv
hw/mips_store_align.sv
hw/mips_load_extract.sv
hw/mips_data_ram.sv
hw/mips_mem_stage.sv
sim/mips_mem_checker.sv
sim/mips_mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --top-module mips_mem_stage_tb \
    -f mips_mem_stage.f -o mips_mem_stage_sim

./obj_dir/mips_mem_stage_sim > sim.log 2>&1
tail -n 2 sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
